// File: include/dsp_opmode.svh
`ifndef DSP_OPMODE_SVH
`define DSP_OPMODE_SVH

// X mux select, opmode bits 1:0
`define DSP_XSEL_MASK 8'h03
`define DSP_XIN_MULT  8'h01

// Z mux select, opmode bits 3:2
`define DSP_ZSEL_MASK 8'h0C
`define DSP_ZIN_ZERO  8'h00
`define DSP_ZIN_PCIN  8'h04

// X mux idle, P register holds
`define DSP_NOP       8'h00

`endif

// File: rtl/iir_pkg.sv
package iir_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------
    localparam int SAMPLE_W = 18;
    localparam int ACC_W    = 48;

    // Biquad has b0, b1, b2, a1, a2
    localparam int NUM_TAPS = 5;

    // Q2.16 result taken from the accumulator at this bit
    localparam int RES_LSB  = 16;

    // ------------------------------------------------------------
    // Data types
    // ------------------------------------------------------------
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [SAMPLE_W-1:0] coef_t;
    typedef logic signed [ACC_W-1:0]    acc_t;

    // ------------------------------------------------------------
    // Configuration port
    // ------------------------------------------------------------
    typedef logic [2:0] cfg_addr_t;

    // Addresses 0..4 hit the coefficients, 5 the control word
    localparam cfg_addr_t CFG_ADDR_CTRL = 3'd5;

    typedef struct packed {
        logic                bypass;
        logic [SAMPLE_W-2:0] rsvd;
    } ctrl_word_t;

    // Same write word, read as coefficient or as control
    typedef union packed {
        coef_t      coef;
        ctrl_word_t ctrl;
    } cfg_word_u;

endpackage

// File: rtl/iir_coef_regs.sv
`timescale 1ns/100ps

module iir_coef_regs (
    input  logic               reset,
    input  logic               clk,
    input  logic               cfg_wr,
    input  iir_pkg::cfg_addr_t cfg_addr,
    input  iir_pkg::cfg_word_u cfg_data,
    input  logic               coef_commit,
    output iir_pkg::coef_t     coefs [iir_pkg::NUM_TAPS],
    output logic               bypass
);
    import iir_pkg::*;

    coef_t shadow_coefs [NUM_TAPS];
    logic  shadow_bypass;

    // ------------------------------------------------------------
    // Shadow bank, written by software at any time
    // ------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                shadow_coefs[k] <= '0;
            end
            shadow_bypass <= 1'b0;
        end else if (cfg_wr) begin
            // Address decides how the word is read
            if (cfg_addr < cfg_addr_t'(NUM_TAPS)) begin
                shadow_coefs[cfg_addr] <= cfg_data.coef;
            end else if (cfg_addr == CFG_ADDR_CTRL) begin
                shadow_bypass <= cfg_data.ctrl.bypass;
            end
        end
    end

    // ------------------------------------------------------------
    // Active bank, seen by the sequencer
    // ------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                coefs[k] <= '0;
            end
            bypass <= 1'b0;
        end else if (coef_commit) begin
            coefs  <= shadow_coefs;
            bypass <= shadow_bypass;
        end
    end

    // Software may only address the five taps and the control word
    a_cfg_addr_range : assert property (
        @(posedge reset) disable iff (clk)
        cfg_wr |-> (cfg_addr <= CFG_ADDR_CTRL)
    ) else $error("write to unmapped config address %0d", cfg_addr);

endmodule

// File: rtl/iir_sample_fifo.sv
`timescale 1ns/100ps

module iir_sample_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic             reset,
    input  logic             clk,
    input  logic             in_valid,
    input  iir_pkg::sample_t in_sample,
    input  logic             fifo_pop,
    output iir_pkg::sample_t fifo_data,
    output logic             fifo_empty,
    output logic             in_credit
);
    import iir_pkg::*;

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    sample_t       mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    // Circular increment, also for depths that are not a power of two
    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
        if (ptr == AW'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign fifo_data  = mem[rd_ptr];
    assign fifo_empty = (count == '0);

    always_ff @(posedge reset) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_sample;
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            in_credit <= 1'b0;
        end else begin
            if (in_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (fifo_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({in_valid, fifo_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Every consumed entry goes back to the sender as a credit
            in_credit <= fifo_pop;
        end
    end

    a_no_overflow : assert property (
        @(posedge reset) disable iff (clk)
        in_valid |-> (count != CW'(FIFO_DEPTH))
    ) else $error("sample written without credit, FIFO full");

    a_no_underflow : assert property (
        @(posedge reset) disable iff (clk)
        fifo_pop |-> !fifo_empty
    ) else $error("sequencer popped an empty FIFO");

endmodule

// File: rtl/alu_filter_iir.sv
`timescale 1ns/100ps
`include "dsp_opmode.svh"

module alu_filter_iir (
    input  logic             reset,
    input  logic             clk,
    input  iir_pkg::sample_t fifo_data,
    input  logic             fifo_empty,
    output logic             fifo_pop,
    input  iir_pkg::coef_t   coefs [iir_pkg::NUM_TAPS],
    input  logic             bypass,
    output logic             coef_commit,
    input  logic             out_credit,
    output iir_pkg::sample_t sample_out,
    output logic             sample_out_valid,
    output logic [7:0]       dsp_opmode,
    output iir_pkg::coef_t   dsp_a,
    output iir_pkg::sample_t dsp_b,
    input  iir_pkg::acc_t    dsp_p
);
    import iir_pkg::*;

    // ------------------------------------------------------------
    // Task bits of the microcode
    // ------------------------------------------------------------
    localparam logic [10:0] NOP      = 11'h000;
    localparam logic [10:0] WAIT_IN  = 11'h001;
    localparam logic [10:0] PUSH_X   = 11'h002;
    localparam logic [10:0] MOV_I_1  = 11'h004;
    localparam logic [10:0] ISSUE_B0 = 11'h008;
    localparam logic [10:0] ISSUE_CI = 11'h010;
    localparam logic [10:0] INC_I    = 11'h020;
    localparam logic [10:0] REPEAT_4 = 11'h040;
    localparam logic [10:0] MOV_RES  = 11'h080;
    localparam logic [10:0] PUSH_Y   = 11'h100;
    localparam logic [10:0] COMMIT   = 11'h200;
    localparam logic [10:0] JUMP     = 11'h400;

    localparam logic [3:0] PC_START = 4'd0;
    localparam logic [3:0] PC_ISSUE = 4'd1;

    logic [10:0] tasks;
    logic [3:0]  pc;
    logic [1:0]  rep_cnt;
    logic [2:0]  idx;
    logic [7:0]  out_credits;
    sample_t     dly [NUM_TAPS];
    sample_t     y_sel;
    logic        go;

    // A sample starts only with data waiting and room downstream
    assign go          = !fifo_empty && (out_credits != 8'd0);
    assign fifo_pop    = |(tasks & PUSH_X);
    assign coef_commit = |(tasks & COMMIT);

    // Bypass keeps the program running and only swaps the result
    assign y_sel = bypass ? dly[0] : dsp_p[RES_LSB +: SAMPLE_W];

    always_comb begin
        case (pc)
            4'd0:    tasks = WAIT_IN | COMMIT;
            4'd1:    tasks = PUSH_X | MOV_I_1 | ISSUE_B0;
            4'd2:    tasks = REPEAT_4 | ISSUE_CI | INC_I;
            4'd3:    tasks = NOP;
            4'd4:    tasks = NOP;
            4'd5:    tasks = MOV_RES | PUSH_Y;
            4'd6:    tasks = COMMIT;
            4'd7:    tasks = NOP;
            default: tasks = JUMP;
        endcase
    end

    // ------------------------------------------------------------
    // Program counter, repeat counter, index register
    // ------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            pc <= PC_START;
        end else if (|(tasks & JUMP)) begin
            // Skip the idle state when the next sample is ready
            pc <= go ? PC_ISSUE : PC_START;
        end else if (|(tasks & WAIT_IN) && !go) begin
            pc <= pc;
        end else if (|(tasks & REPEAT_4) && (rep_cnt != 2'd3)) begin
            pc <= pc;
        end else begin
            pc <= pc + 4'd1;
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            rep_cnt <= '0;
            idx     <= '0;
        end else begin
            if (|(tasks & REPEAT_4)) begin
                rep_cnt <= rep_cnt + 2'd1;
            end
            if (|(tasks & MOV_I_1)) begin
                idx <= 3'd1;
            end else if (|(tasks & INC_I)) begin
                idx <= idx + 3'd1;
            end
        end
    end

    // Delay line x, x1, x2, y1, y2
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                dly[k] <= '0;
            end
        end else begin
            if (|(tasks & PUSH_X)) begin
                dly[0] <= fifo_data;
                dly[1] <= dly[0];
                dly[2] <= dly[1];
            end
            if (|(tasks & PUSH_Y)) begin
                dly[3] <= y_sel;
                dly[4] <= dly[3];
            end
        end
    end

    // ------------------------------------------------------------
    // Slice operand issue
    // ------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            dsp_opmode <= `DSP_NOP;
        end else if (|(tasks & ISSUE_B0)) begin
            dsp_opmode <= `DSP_XIN_MULT | `DSP_ZIN_ZERO;
        end else if (|(tasks & ISSUE_CI)) begin
            dsp_opmode <= `DSP_XIN_MULT | `DSP_ZIN_PCIN;
        end else begin
            dsp_opmode <= `DSP_NOP;
        end
    end

    always_ff @(posedge reset) begin
        if (|(tasks & ISSUE_B0)) begin
            dsp_a <= coefs[0];
            dsp_b <= fifo_data;
        end else if (|(tasks & ISSUE_CI)) begin
            dsp_a <= coefs[idx];
            dsp_b <= dly[idx];
        end
    end

    // ------------------------------------------------------------
    // Result and output credits
    // ------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            sample_out_valid <= 1'b0;
        end else begin
            sample_out_valid <= |(tasks & MOV_RES);
        end
    end

    always_ff @(posedge reset) begin
        if (|(tasks & MOV_RES)) begin
            sample_out <= y_sel;
        end
    end

    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            out_credits <= '0;
        end else begin
            case ({out_credit, sample_out_valid})
                2'b10:   out_credits <= out_credits + 8'd1;
                2'b01:   out_credits <= out_credits - 8'd1;
                default: out_credits <= out_credits;
            endcase
        end
    end

    a_out_credit_held : assert property (
        @(posedge reset) disable iff (clk)
        sample_out_valid |-> (out_credits != 8'd0)
    ) else $error("output sent without a downstream credit");

endmodule

// File: rtl/dsp_mac_slice.sv
`timescale 1ns/100ps
`include "dsp_opmode.svh"

module dsp_mac_slice (
    input  logic             reset,
    input  logic             clk,
    input  logic [7:0]       dsp_opmode,
    input  iir_pkg::coef_t   dsp_a,
    input  iir_pkg::sample_t dsp_b,
    output iir_pkg::acc_t    dsp_p
);
    import iir_pkg::*;

    logic [7:0]                   op_m;
    logic signed [2*SAMPLE_W-1:0] m_reg;
    acc_t                         m_ext;
    logic [7:0]                   x_sel;
    logic [7:0]                   z_sel;

    // Product sign-extended to the accumulator width
    assign m_ext = acc_t'(m_reg);

    assign x_sel = op_m & `DSP_XSEL_MASK;
    assign z_sel = op_m & `DSP_ZSEL_MASK;

    // ------------------------------------------------------------
    // M stage
    // ------------------------------------------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            op_m <= `DSP_NOP;
        end else begin
            op_m <= dsp_opmode;
        end
    end

    always_ff @(posedge reset) begin
        m_reg <= dsp_a * dsp_b;
    end

    // ------------------------------------------------------------
    // P stage
    // ------------------------------------------------------------
    always_ff @(posedge reset) begin
        if (x_sel == `DSP_XIN_MULT) begin
            case (z_sel)
                // Load starts a new sum
                `DSP_ZIN_ZERO: dsp_p <= m_ext;
                `DSP_ZIN_PCIN: dsp_p <= dsp_p + m_ext;
                default:       dsp_p <= dsp_p;
            endcase
        end
        // NOP and other X selects hold P
    end

endmodule

// File: rtl/iir_filter_top.sv
`timescale 1ns/100ps

module iir_filter_top #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic               reset,
    input  logic               clk,
    input  logic               cfg_wr,
    input  iir_pkg::cfg_addr_t cfg_addr,
    input  iir_pkg::cfg_word_u cfg_data,
    input  logic               in_valid,
    input  iir_pkg::sample_t   in_sample,
    output logic               in_credit,
    input  logic               out_credit,
    output iir_pkg::sample_t   sample_out,
    output logic               sample_out_valid
);
    import iir_pkg::*;

    sample_t    fifo_data;
    logic       fifo_empty;
    logic       fifo_pop;
    coef_t      coefs [NUM_TAPS];
    logic       bypass;
    logic       coef_commit;
    logic [7:0] dsp_opmode;
    coef_t      dsp_a;
    sample_t    dsp_b;
    acc_t       dsp_p;

    iir_sample_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_fifo (
        .reset      (reset),
        .clk        (clk),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .fifo_pop   (fifo_pop),
        .fifo_data  (fifo_data),
        .fifo_empty (fifo_empty),
        .in_credit  (in_credit)
    );

    iir_coef_regs i_regs (
        .reset       (reset),
        .clk         (clk),
        .cfg_wr      (cfg_wr),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .coef_commit (coef_commit),
        .coefs       (coefs),
        .bypass      (bypass)
    );

    // Sequencer and the slice it time-shares
    alu_filter_iir i_seq (
        .reset            (reset),
        .clk              (clk),
        .fifo_data        (fifo_data),
        .fifo_empty       (fifo_empty),
        .fifo_pop         (fifo_pop),
        .coefs            (coefs),
        .bypass           (bypass),
        .coef_commit      (coef_commit),
        .out_credit       (out_credit),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid),
        .dsp_opmode       (dsp_opmode),
        .dsp_a            (dsp_a),
        .dsp_b            (dsp_b),
        .dsp_p            (dsp_p)
    );

    dsp_mac_slice i_slice (
        .reset      (reset),
        .clk        (clk),
        .dsp_opmode (dsp_opmode),
        .dsp_a      (dsp_a),
        .dsp_b      (dsp_b),
        .dsp_p      (dsp_p)
    );

endmodule

// File: bench/tb_iir_filter.sv
`timescale 1ns/100ps

module tb_iir_filter;
    import iir_pkg::*;

    localparam int FIFO_DEPTH = 4;
    localparam int ROWS       = 6;
    localparam int MAX_LEN    = 12;
    localparam logic [31:0] SEED = 32'h9abd_3cec;

    // Clock on the port named reset, async reset on the port named clk
    logic      reset;
    logic      clk;
    logic      cfg_wr;
    cfg_addr_t cfg_addr;
    cfg_word_u cfg_data;
    logic      in_valid;
    sample_t   in_sample;
    logic      in_credit;
    logic      out_credit;
    sample_t   sample_out;
    logic      sample_out_valid;

    // ------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------
    coef_t   row_coef   [ROWS][NUM_TAPS];
    coef_t   row_coef2  [ROWS][NUM_TAPS];
    logic    row_bypass [ROWS];
    logic    row_hand   [ROWS];
    int      row_len    [ROWS];
    int      row_stall  [ROWS];
    int      row_switch [ROWS];
    sample_t row_x      [ROWS][MAX_LEN];
    sample_t row_exp    [ROWS][MAX_LEN];

    // Reference model state
    sample_t m_x1;
    sample_t m_x2;
    sample_t m_y1;
    sample_t m_y2;

    sample_t exp_q [$];
    int      pop_cycles [$];
    int      cycle;
    int      in_credits;
    int      sent_total;
    int      returned_total;
    int      outs_seen;
    int      errors;
    int      checks;

    iir_filter_top #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_dut (
        .reset            (reset),
        .clk              (clk),
        .cfg_wr           (cfg_wr),
        .cfg_addr         (cfg_addr),
        .cfg_data         (cfg_data),
        .in_valid         (in_valid),
        .in_sample        (in_sample),
        .in_credit        (in_credit),
        .out_credit       (out_credit),
        .sample_out       (sample_out),
        .sample_out_valid (sample_out_valid)
    );

    always #10 reset = ~reset;

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_sample(input sample_t got, input sample_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_credit_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERR %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERR %0t: pop to output took %0d cycles, expected %0d", $time, got, exp);
        end
    endtask

    // Q2.16 biquad step, 48-bit sum, bits 33:16 kept with wrap
    function automatic sample_t model_step(input int r, input bit use_new, input sample_t x);
        coef_t   c [NUM_TAPS];
        acc_t    acc;
        sample_t y;
        for (int k = 0; k < NUM_TAPS; k++) begin
            c[k] = use_new ? row_coef2[r][k] : row_coef[r][k];
        end
        acc = acc_t'(c[0]) * acc_t'(x) + acc_t'(c[1]) * acc_t'(m_x1)
            + acc_t'(c[2]) * acc_t'(m_x2) + acc_t'(c[3]) * acc_t'(m_y1)
            + acc_t'(c[4]) * acc_t'(m_y2);
        y = row_bypass[r] ? x : acc[33:16];
        m_x2 = m_x1;
        m_x1 = x;
        m_y2 = m_y1;
        m_y1 = y;
        return y;
    endfunction

    function automatic sample_t rand_sample();
        return sample_t'($urandom) >>> 1;
    endfunction

    function automatic coef_t rand_coef();
        return coef_t'($urandom) >>> 2;
    endfunction

    task automatic build_table();
        logic use_new;
        sample_t y;
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                row_coef[r][k]  = (r >= 2) ? rand_coef() : '0;
                row_coef2[r][k] = rand_coef();
            end
            for (int k = 0; k < MAX_LEN; k++) begin
                row_x[r][k] = rand_sample();
            end
            row_bypass[r] = 1'b0;
            row_hand[r]   = 1'b0;
            row_stall[r]  = 0;
            row_switch[r] = -1;
            row_len[r]    = (r >= 4) ? 8 : 12;
        end
        // Impulse through b0 = 0.5, then b0 = 1.0 with a1 = 0.5
        row_len[0] = 4;
        row_len[1] = 6;
        row_hand[0] = 1'b1;
        row_hand[1] = 1'b1;
        row_coef[0][0] = 18'h08000;
        row_coef[1][0] = 18'h10000;
        row_coef[1][3] = 18'h08000;
        for (int k = 0; k < MAX_LEN; k++) begin
            row_x[0][k] = (k == 0) ? 18'h10000 : '0;
            row_x[1][k] = (k == 0) ? 18'h10000 : '0;
            row_exp[0][k] = (k == 0) ? 18'h08000 : '0;
            row_exp[1][k] = sample_t'(18'h10000 >> k);
        end
        row_switch[3] = 4;
        row_stall[4]  = 60;
        row_bypass[5] = 1'b1;
        m_x1 = '0;
        m_x2 = '0;
        m_y1 = '0;
        m_y2 = '0;
        for (int r = 0; r < ROWS; r++) begin
            for (int k = 0; k < row_len[r]; k++) begin
                // Set written after output m reaches samples from m+2 on
                use_new = (row_switch[r] >= 0) && (k >= row_switch[r] + 2);
                y = model_step(r, use_new, row_x[r][k]);
                if (!row_hand[r]) begin
                    row_exp[r][k] = y;
                end
            end
        end
    endtask

    // ------------------------------------------------------------
    // Drivers, all acting 2 ns after the rising edge
    // ------------------------------------------------------------
    task automatic next_slot();
        @(posedge reset);
        #2;
    endtask

    task automatic write_cfg(input cfg_addr_t addr, input cfg_word_u data);
        cfg_wr   = 1'b1;
        cfg_addr = addr;
        cfg_data = data;
        next_slot();
        cfg_wr   = 1'b0;
    endtask

    task automatic write_coefs(input int r, input bit second);
        cfg_word_u w;
        for (int k = 0; k < NUM_TAPS; k++) begin
            w.coef = second ? row_coef2[r][k] : row_coef[r][k];
            write_cfg(cfg_addr_t'(k), w);
        end
    endtask

    task automatic write_ctrl(input logic byp);
        cfg_word_u w;
        w = '0;
        w.ctrl.bypass = byp;
        write_cfg(CFG_ADDR_CTRL, w);
    endtask

    task automatic send_samples(input int r);
        int k;
        k = 0;
        while (k < row_len[r]) begin
            if (in_credits > 0) begin
                in_valid  = 1'b1;
                in_sample = row_x[r][k];
                in_credits--;
                sent_total++;
                k++;
            end else begin
                in_valid = 1'b0;
            end
            next_slot();
        end
        in_valid = 1'b0;
    endtask

    task automatic grant_out_credits(input int r, input int base);
        int first;
        first = (row_stall[r] > 0) ? 1 : row_len[r];
        repeat (first) begin
            out_credit = 1'b1;
            next_slot();
        end
        out_credit = 1'b0;
        if (row_stall[r] > 0) begin
            repeat (row_stall[r]) next_slot();
            // Downstream idle, so output and input credits both stop
            check_credit_count(outs_seen - base, 1, "outputs during stall");
            check_credit_count(in_credits, 0, "sender credits during stall");
            repeat (row_len[r] - 1) begin
                out_credit = 1'b1;
                next_slot();
            end
            out_credit = 1'b0;
        end
    endtask

    task automatic switch_coefs(input int r, input int base);
        if (row_switch[r] >= 0) begin
            wait (outs_seen >= base + row_switch[r] + 1);
            next_slot();
            write_coefs(r, 1'b1);
        end
    endtask

    task automatic run_row(input int r);
        int base;
        base = outs_seen;
        write_coefs(r, 1'b0);
        write_ctrl(row_bypass[r]);
        for (int k = 0; k < row_len[r]; k++) begin
            exp_q.push_back(row_exp[r][k]);
        end
        fork
            send_samples(r);
            grant_out_credits(r, base);
            switch_coefs(r, base);
            wait (outs_seen == base + row_len[r]);
        join
        next_slot();
        check_credit_count(outs_seen - base, row_len[r], "outputs in row");
        check_credit_count(returned_total, sent_total, "input credits returned");
        check_credit_count(in_credits, FIFO_DEPTH, "sender credits after drain");
    endtask

    // ------------------------------------------------------------
    // Monitor
    // ------------------------------------------------------------
    always @(posedge reset) begin
        cycle++;
        if (!clk) begin
            if (in_credit) begin
                in_credits++;
                returned_total++;
                // Credit comes one cycle after the pop
                pop_cycles.push_back(cycle - 1);
                if (in_credits > FIFO_DEPTH) begin
                    errors++;
                    $display("sender holds %0d input credits, more than the FIFO depth",
                             in_credits);
                end
            end
            if (sample_out_valid) begin
                if (exp_q.size() == 0 || pop_cycles.size() == 0) begin
                    errors++;
                    $display("output sample %h arrived with no sample outstanding", sample_out);
                end else begin
                    check_sample(sample_out, exp_q.pop_front(), "sample_out");
                    check_latency(cycle - pop_cycles.pop_front(), 8);
                end
                outs_seen++;
            end
        end
    end

    initial begin
        int limit;
        reset      = 1'b0;
        clk        = 1'b1;
        cfg_wr     = 1'b0;
        cfg_addr   = '0;
        cfg_data   = '0;
        in_valid   = 1'b0;
        in_sample  = '0;
        out_credit = 1'b0;
        cycle          = 0;
        in_credits     = FIFO_DEPTH;
        sent_total     = 0;
        returned_total = 0;
        outs_seen      = 0;
        errors         = 0;
        checks         = 0;
        void'($urandom(SEED));
        build_table();
        limit = 200;
        for (int r = 0; r < ROWS; r++) begin
            limit += row_len[r] * 11 + row_stall[r] + 50;
        end
        fork
            begin
                repeat (limit) @(posedge reset);
                $display("timeout after %0d cycles, outputs seen %0d", limit, outs_seen);
                $display("RESULT: FAIL");
                $finish;
            end
        join_none
        repeat (10) @(posedge reset);
        #2;
        clk = 1'b0;
        if (sample_out_valid !== 1'b0 || in_credit !== 1'b0) begin
            errors++;
            $display("outputs not low after reset");
        end
        for (int r = 0; r < ROWS; r++) begin
            run_row(r);
        end
        // Quiet tail catches stray or duplicated outputs
        repeat (30) next_slot();
        check_credit_count(in_credits, FIFO_DEPTH, "final sender credits");
        check_credit_count(returned_total, sent_total, "final credits returned");
        $display("checks %0d, errors %0d, samples %0d, outputs %0d",
                 checks, errors, sent_total, outs_seen);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+include
rtl/iir_pkg.sv
rtl/iir_coef_regs.sv
rtl/iir_sample_fifo.sv
rtl/alu_filter_iir.sv
rtl/dsp_mac_slice.sv
rtl/iir_filter_top.sv
bench/tb_iir_filter.sv

// File: Makefile
# Verilator build and run of the biquad testbench

VERILATOR ?= verilator
TOP       ?= tb_iir_filter
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
